//--- hdl/id_pkg.sv
// decode stage shared types
package id_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]   word_t;

    //////////////////////////////////////////////////
    // instruction fields
    //////////////////////////////////////////////////
    localparam int RD_LSB      = 0;
    localparam int RD_MSB      = 4;
    localparam int RJ_LSB      = 5;
    localparam int RJ_MSB      = 9;
    localparam int RK_LSB      = 10;  // also ui5 of the immediate shifts
    localparam int RK_MSB      = 14;
    localparam int SI12_LSB    = 10;
    localparam int SI12_MSB    = 21;
    localparam int OFFS16_LSB  = 10;  // offs26 high part too
    localparam int OFFS16_MSB  = 25;
    localparam int OFFS26L_LSB = 0;
    localparam int OFFS26L_MSB = 9;
    localparam int SI20_LSB    = 5;
    localparam int SI20_MSB    = 24;

    localparam reg_addr_t REG_ZERO = 5'd0;
    localparam reg_addr_t REG_LINK = 5'd1;  // BL return address

    //////////////////////////////////////////////////
    // sub-opcodes within each class
    //////////////////////////////////////////////////
    typedef enum logic [5:0] {  // inst[31:26]
        OPC_JIRL = 6'b010011, OPC_B    = 6'b010100, OPC_BL   = 6'b010101,
        OPC_BEQ  = 6'b010110, OPC_BNE  = 6'b010111, OPC_BLT  = 6'b011000,
        OPC_BGE  = 6'b011001, OPC_BLTU = 6'b011010, OPC_BGEU = 6'b011011
    } br_opc_e;

    typedef enum logic [3:0] {  // inst[25:22]
        OPC_LD_B  = 4'h0, OPC_LD_H  = 4'h1, OPC_LD_W = 4'h2, OPC_ST_B = 4'h4,
        OPC_ST_H  = 4'h5, OPC_ST_W  = 4'h6, OPC_LD_BU = 4'h8, OPC_LD_HU = 4'h9
    } mem_opc_e;

    localparam logic [2:0] OPC_LU12I_W = 3'b010;  // inst[27:25]

    typedef enum logic [2:0] {  // inst[24:22]
        OPC_SLTI = 3'b000, OPC_SLTUI = 3'b001, OPC_ADDI_W = 3'b010,
        OPC_ANDI = 3'b101, OPC_ORI   = 3'b110, OPC_XORI   = 3'b111
    } imm_opc_e;

    typedef enum logic [6:0] {  // inst[21:15]
        OPC_SLLI_W = 7'b0000001, OPC_SRLI_W = 7'b0001001, OPC_SRAI_W = 7'b0010001
    } sft_opc_e;

    typedef enum logic [4:0] {  // inst[19:15]
        OPC_ADD_W  = 5'b00000, OPC_SUB_W  = 5'b00010, OPC_SLT     = 5'b00100,
        OPC_SLTU   = 5'b00101, OPC_NOR    = 5'b01000, OPC_AND     = 5'b01001,
        OPC_OR     = 5'b01010, OPC_XOR    = 5'b01011, OPC_SLL_W   = 5'b01110,
        OPC_SRL_W  = 5'b01111, OPC_SRA_W  = 5'b10000, OPC_MUL_W   = 5'b11000,
        OPC_MULH_W = 5'b11001, OPC_MULH_WU = 5'b11010
    } rr_opc_e;

    //////////////////////////////////////////////////
    // decoded operation, grouped by result class
    //////////////////////////////////////////////////
    typedef enum logic [4:0] {
        OP_NOP,
        OP_AND, OP_OR, OP_NOR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_MUL, OP_MULH, OP_MULHU,
        OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU, OP_ST_B, OP_ST_H, OP_ST_W,
        OP_JIRL, OP_B, OP_BL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_LOAD_STORE, SEL_BRANCH
    } alu_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JIRL, BR_B, BR_BL, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_kind_e;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_src_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        logic      we;
        reg_addr_t waddr;
        logic      reg1_re;
        logic      reg2_re;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        br_kind_e  br_kind;
    } dec_ctrl_t;

    typedef struct packed {
        logic  flag;
        word_t target;
        logic  next_in_delayslot;
    } branch_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        word_t     reg1;
        word_t     reg2;
        word_t     imm;
        reg_addr_t waddr;
        logic      we;
        word_t     link_addr;
        logic      is_in_delayslot;
    } ex_bundle_t;

endpackage

//--- hdl/inst_decoder.sv
// instruction decoder
`timescale 1ns/1ps

module inst_decoder (
    input  id_pkg::word_t     inst_i,
    output id_pkg::dec_ctrl_t ctrl_o,
    output id_pkg::word_t     imm_o
);
    import id_pkg::*;

    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    word_t     si12_zext;
    word_t     si12_sext;
    br_opc_e   br_opc;
    mem_opc_e  mem_opc;
    imm_opc_e  imm_opc;
    sft_opc_e  sft_opc;
    rr_opc_e   rr_opc;

    assign rd        = inst_i[RD_MSB:RD_LSB];
    assign rj        = inst_i[RJ_MSB:RJ_LSB];
    assign rk        = inst_i[RK_MSB:RK_LSB];
    assign si12_zext = {{(XLEN-12){1'b0}}, inst_i[SI12_MSB:SI12_LSB]};
    assign si12_sext = {{(XLEN-12){inst_i[SI12_MSB]}}, inst_i[SI12_MSB:SI12_LSB]};

    assign br_opc  = br_opc_e'(inst_i[31:26]);
    assign mem_opc = mem_opc_e'(inst_i[25:22]);
    assign imm_opc = imm_opc_e'(inst_i[24:22]);
    assign sft_opc = sft_opc_e'(inst_i[21:15]);
    assign rr_opc  = rr_opc_e'(inst_i[19:15]);

    always_comb begin
        ctrl_o        = '0;  // unknown opcode stays a NOP
        ctrl_o.raddr1 = rj;
        ctrl_o.raddr2 = rk;
        imm_o         = '0;

        //////////////////////////////////////////////////
        // class markers, highest first
        //////////////////////////////////////////////////
        if (inst_i[30]) begin
            case (br_opc)
                OPC_JIRL: ctrl_o.aluop = OP_JIRL;
                OPC_B:    ctrl_o.aluop = OP_B;
                OPC_BL:   ctrl_o.aluop = OP_BL;
                OPC_BEQ:  ctrl_o.aluop = OP_BEQ;
                OPC_BNE:  ctrl_o.aluop = OP_BNE;
                OPC_BLT:  ctrl_o.aluop = OP_BLT;
                OPC_BGE:  ctrl_o.aluop = OP_BGE;
                OPC_BLTU: ctrl_o.aluop = OP_BLTU;
                OPC_BGEU: ctrl_o.aluop = OP_BGEU;
                default:  ctrl_o.aluop = OP_NOP;
            endcase
            if (ctrl_o.aluop == OP_JIRL) begin
                ctrl_o.reg1_re = 1'b1;
                ctrl_o.we      = 1'b1;
                ctrl_o.waddr   = rd;
            end else if (ctrl_o.aluop == OP_BL) begin
                ctrl_o.we    = 1'b1;
                ctrl_o.waddr = REG_LINK;
            end else if (ctrl_o.aluop inside {[OP_BEQ:OP_BGEU]}) begin
                ctrl_o.reg1_re = 1'b1;
                ctrl_o.reg2_re = 1'b1;
                ctrl_o.raddr2  = rd;  // compared against rj
            end
        end else if (inst_i[29]) begin
            case (mem_opc)
                OPC_LD_B:  ctrl_o.aluop = OP_LD_B;
                OPC_LD_H:  ctrl_o.aluop = OP_LD_H;
                OPC_LD_W:  ctrl_o.aluop = OP_LD_W;
                OPC_LD_BU: ctrl_o.aluop = OP_LD_BU;
                OPC_LD_HU: ctrl_o.aluop = OP_LD_HU;
                OPC_ST_B:  ctrl_o.aluop = OP_ST_B;
                OPC_ST_H:  ctrl_o.aluop = OP_ST_H;
                OPC_ST_W:  ctrl_o.aluop = OP_ST_W;
                default:   ctrl_o.aluop = OP_NOP;
            endcase
            if (ctrl_o.aluop inside {[OP_ST_B:OP_ST_W]}) begin
                ctrl_o.reg1_re = 1'b1;
                ctrl_o.reg2_re = 1'b1;
                ctrl_o.raddr2  = rd;  // store data
                imm_o          = si12_sext;
            end else if (ctrl_o.aluop != OP_NOP) begin
                ctrl_o.reg1_re = 1'b1;
                ctrl_o.we      = 1'b1;
                ctrl_o.waddr   = rd;
                imm_o          = si12_sext;
            end
        end else if (inst_i[28]) begin
            if (inst_i[27:25] == OPC_LU12I_W) begin
                ctrl_o.aluop   = OP_OR;  // r0 | (si20 << 12)
                ctrl_o.reg1_re = 1'b1;
                ctrl_o.raddr1  = REG_ZERO;
                ctrl_o.we      = 1'b1;
                ctrl_o.waddr   = rd;
                imm_o          = {inst_i[SI20_MSB:SI20_LSB], 12'b0};
            end
        end else if (inst_i[25]) begin
            case (imm_opc)
                OPC_SLTI:   ctrl_o.aluop = OP_SLT;
                OPC_SLTUI:  ctrl_o.aluop = OP_SLTU;
                OPC_ADDI_W: ctrl_o.aluop = OP_ADD;
                OPC_ANDI:   ctrl_o.aluop = OP_AND;
                OPC_ORI:    ctrl_o.aluop = OP_OR;
                OPC_XORI:   ctrl_o.aluop = OP_XOR;
                default:    ctrl_o.aluop = OP_NOP;
            endcase
            if (ctrl_o.aluop != OP_NOP) begin
                ctrl_o.reg1_re = 1'b1;
                ctrl_o.we      = 1'b1;
                ctrl_o.waddr   = rd;
                imm_o = (ctrl_o.aluop inside {[OP_AND:OP_XOR]}) ? si12_zext : si12_sext;
            end
        end else if (inst_i[22]) begin
            case (sft_opc)
                OPC_SLLI_W: ctrl_o.aluop = OP_SLL;
                OPC_SRLI_W: ctrl_o.aluop = OP_SRL;
                OPC_SRAI_W: ctrl_o.aluop = OP_SRA;
                default:    ctrl_o.aluop = OP_NOP;
            endcase
            if (ctrl_o.aluop != OP_NOP) begin
                ctrl_o.reg1_re = 1'b1;
                ctrl_o.we      = 1'b1;
                ctrl_o.waddr   = rd;
                imm_o          = {{(XLEN-REG_AW){1'b0}}, rk};  // ui5
            end
        end else if (inst_i[20]) begin
            case (rr_opc)
                OPC_AND:     ctrl_o.aluop = OP_AND;
                OPC_OR:      ctrl_o.aluop = OP_OR;
                OPC_NOR:     ctrl_o.aluop = OP_NOR;
                OPC_XOR:     ctrl_o.aluop = OP_XOR;
                OPC_SLL_W:   ctrl_o.aluop = OP_SLL;
                OPC_SRL_W:   ctrl_o.aluop = OP_SRL;
                OPC_SRA_W:   ctrl_o.aluop = OP_SRA;
                OPC_ADD_W:   ctrl_o.aluop = OP_ADD;
                OPC_SUB_W:   ctrl_o.aluop = OP_SUB;
                OPC_SLT:     ctrl_o.aluop = OP_SLT;
                OPC_SLTU:    ctrl_o.aluop = OP_SLTU;
                OPC_MUL_W:   ctrl_o.aluop = OP_MUL;
                OPC_MULH_W:  ctrl_o.aluop = OP_MULH;
                OPC_MULH_WU: ctrl_o.aluop = OP_MULHU;
                default:     ctrl_o.aluop = OP_NOP;
            endcase
            if (ctrl_o.aluop != OP_NOP) begin
                ctrl_o.reg1_re = 1'b1;
                ctrl_o.reg2_re = 1'b1;
                ctrl_o.we      = 1'b1;
                ctrl_o.waddr   = rd;
            end
        end

        // result class follows the operation grouping
        if (ctrl_o.aluop inside {[OP_AND:OP_XOR]})
            ctrl_o.alusel = SEL_LOGIC;
        else if (ctrl_o.aluop inside {[OP_SLL:OP_SRA]})
            ctrl_o.alusel = SEL_SHIFT;
        else if (ctrl_o.aluop inside {[OP_ADD:OP_MULHU]})
            ctrl_o.alusel = SEL_ARITH;
        else if (ctrl_o.aluop inside {[OP_LD_B:OP_ST_W]})
            ctrl_o.alusel = SEL_LOAD_STORE;
        else if (ctrl_o.aluop inside {[OP_JIRL:OP_BGEU]})
            ctrl_o.alusel = SEL_BRANCH;
        else
            ctrl_o.alusel = SEL_NOP;

        case (ctrl_o.aluop)
            OP_JIRL: ctrl_o.br_kind = BR_JIRL;
            OP_B:    ctrl_o.br_kind = BR_B;
            OP_BL:   ctrl_o.br_kind = BR_BL;
            OP_BEQ:  ctrl_o.br_kind = BR_EQ;
            OP_BNE:  ctrl_o.br_kind = BR_NE;
            OP_BLT:  ctrl_o.br_kind = BR_LT;
            OP_BGE:  ctrl_o.br_kind = BR_GE;
            OP_BLTU: ctrl_o.br_kind = BR_LTU;
            OP_BGEU: ctrl_o.br_kind = BR_GEU;
            default: ctrl_o.br_kind = BR_NONE;
        endcase
    end

endmodule

//--- hdl/operand_forward.sv
// source operand forwarding
`timescale 1ns/1ps

module operand_forward (
    input  logic              re_i,
    input  id_pkg::reg_addr_t raddr_i,
    input  id_pkg::word_t     rf_data_i,
    input  id_pkg::word_t     imm_i,
    input  id_pkg::fwd_src_t  ex_fwd_i,
    input  id_pkg::fwd_src_t  mem_fwd_i,
    output id_pkg::word_t     operand_o
);
    import id_pkg::*;

    logic ex_hit;
    logic mem_hit;

    // r0 is hardwired, never forwarded
    assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.waddr == raddr_i) && (raddr_i != REG_ZERO);
    assign mem_hit = mem_fwd_i.we && (mem_fwd_i.waddr == raddr_i) && (raddr_i != REG_ZERO);

    always_comb begin
        if (!re_i) begin
            operand_o = imm_i;             // port not read
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;    // newest result
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

//--- hdl/branch_unit.sv
// branch resolution
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::word_t    pc_i,
    input  id_pkg::word_t    inst_i,
    input  id_pkg::br_kind_e kind_i,
    input  id_pkg::word_t    opnd1_i,
    input  id_pkg::word_t    opnd2_i,
    output id_pkg::branch_t  br_o,
    output id_pkg::word_t    link_addr_o
);
    import id_pkg::*;

    word_t offs16_ext;
    word_t offs26_ext;
    word_t pc_plus_4;
    word_t br_target;
    logic  taken;

    assign pc_plus_4  = pc_i + 32'd4;
    assign offs16_ext = {{(XLEN-18){inst_i[OFFS16_MSB]}},
                         inst_i[OFFS16_MSB:OFFS16_LSB], 2'b00};
    // offs26 sign sits at the top of the low field
    assign offs26_ext = {{(XLEN-28){inst_i[OFFS26L_MSB]}},
                         inst_i[OFFS26L_MSB:OFFS26L_LSB],
                         inst_i[OFFS16_MSB:OFFS16_LSB], 2'b00};

    always_comb begin
        taken     = 1'b0;
        br_target = pc_i + offs16_ext;
        case (kind_i)
            BR_JIRL: begin
                taken     = 1'b1;
                br_target = opnd1_i + offs16_ext;  // register relative
            end
            BR_B, BR_BL: begin
                taken     = 1'b1;
                br_target = pc_i + offs26_ext;
            end
            BR_EQ:   taken = (opnd1_i == opnd2_i);
            BR_NE:   taken = (opnd1_i != opnd2_i);
            BR_LT:   taken = ($signed(opnd1_i) < $signed(opnd2_i));
            BR_GE:   taken = ($signed(opnd1_i) >= $signed(opnd2_i));
            BR_LTU:  taken = (opnd1_i < opnd2_i);
            BR_GEU:  taken = (opnd1_i >= opnd2_i);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        br_o = '0;
        if (taken) begin
            br_o.flag              = 1'b1;
            br_o.target            = br_target;
            br_o.next_in_delayslot = 1'b1;
        end
    end

    assign link_addr_o = (kind_i == BR_JIRL || kind_i == BR_BL) ? pc_plus_4 : '0;

endmodule

//--- hdl/id_ex_reg.sv
// ID/EX pipeline register
`timescale 1ns/1ps

module id_ex_reg (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  id_pkg::ex_bundle_t d_i,
    output id_pkg::ex_bundle_t q_o
);
    import id_pkg::*;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            q_o.aluop           <= OP_NOP;   // bubble toward EX
            q_o.alusel          <= SEL_NOP;
            q_o.reg1            <= '0;
            q_o.reg2            <= '0;
            q_o.imm             <= '0;
            q_o.waddr           <= REG_ZERO;
            q_o.we              <= 1'b0;
            q_o.link_addr       <= '0;
            q_o.is_in_delayslot <= 1'b0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

//--- hdl/id_stage.sv
// instruction decode stage
`timescale 1ns/1ps

module id_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  id_pkg::word_t      pc_i,
    input  id_pkg::word_t      inst_i,
    input  id_pkg::word_t      reg1_i,      // register file, same cycle
    input  id_pkg::word_t      reg2_i,
    input  id_pkg::fwd_src_t   ex_fwd_i,
    input  id_pkg::fwd_src_t   mem_fwd_i,
    input  logic               is_in_delayslot_i,
    output id_pkg::reg_addr_t  raddr1_o,
    output id_pkg::reg_addr_t  raddr2_o,
    output logic               reg1_re_o,
    output logic               reg2_re_o,
    output id_pkg::branch_t    br_o,        // to PC stage, combinational
    output id_pkg::ex_bundle_t ex_o
);
    import id_pkg::*;

    dec_ctrl_t  ctrl;
    word_t      imm;
    word_t      opnd1;
    word_t      opnd2;
    word_t      link_addr;
    ex_bundle_t ex_d;

    inst_decoder dec_i (
        .inst_i (inst_i),
        .ctrl_o (ctrl),
        .imm_o  (imm)
    );

    assign raddr1_o  = ctrl.raddr1;
    assign raddr2_o  = ctrl.raddr2;
    assign reg1_re_o = ctrl.reg1_re;
    assign reg2_re_o = ctrl.reg2_re;

    //////////////////////////////////////////////////
    // operands
    //////////////////////////////////////////////////
    operand_forward fwd1_i (
        .re_i      (ctrl.reg1_re),
        .raddr_i   (ctrl.raddr1),
        .rf_data_i (reg1_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (opnd1)
    );

    operand_forward fwd2_i (
        .re_i      (ctrl.reg2_re),
        .raddr_i   (ctrl.raddr2),
        .rf_data_i (reg2_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (opnd2)
    );

    branch_unit br_unit_i (
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .kind_i      (ctrl.br_kind),
        .opnd1_i     (opnd1),
        .opnd2_i     (opnd2),
        .br_o        (br_o),
        .link_addr_o (link_addr)
    );

    //////////////////////////////////////////////////
    // bundle for execute
    //////////////////////////////////////////////////
    always_comb begin
        ex_d.aluop           = ctrl.aluop;
        ex_d.alusel          = ctrl.alusel;
        ex_d.reg1            = opnd1;
        ex_d.reg2            = opnd2;
        ex_d.imm             = imm;     // store offset rides here
        ex_d.waddr           = ctrl.waddr;
        ex_d.we              = ctrl.we;
        ex_d.link_addr       = link_addr;
        ex_d.is_in_delayslot = is_in_delayslot_i;
    end

    id_ex_reg id_ex_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .d_i     (ex_d),
        .q_o     (ex_o)
    );

endmodule

//--- test/tb_id_model.svh
// decode testbench encoders
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// LoongArch opcode fields, upper bits of the word
localparam logic [16:0] ENC_ADD_W   = 17'h00020;
localparam logic [16:0] ENC_SUB_W   = 17'h00022;
localparam logic [16:0] ENC_SLT     = 17'h00024;
localparam logic [16:0] ENC_AND     = 17'h00029;
localparam logic [16:0] ENC_MUL_W   = 17'h00038;
localparam logic [16:0] ENC_SLLI_W  = 17'h00081;  // ui5 sits in the rk slot
localparam logic [9:0]  ENC_ADDI_W  = 10'h00a;
localparam logic [9:0]  ENC_ORI     = 10'h00e;
localparam logic [9:0]  ENC_LD_W    = 10'h0a2;
localparam logic [9:0]  ENC_ST_W    = 10'h0a6;
localparam logic [6:0]  ENC_LU12I_W = 7'h0a;
localparam logic [5:0]  ENC_JIRL    = 6'h13;
localparam logic [5:0]  ENC_B       = 6'h14;
localparam logic [5:0]  ENC_BL      = 6'h15;
localparam logic [5:0]  ENC_BEQ     = 6'h16;  // BNE..BGEU follow in order

logic [31:0] lcg_state = 32'h8044;

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic word_t enc_3r(input logic [16:0] opc, input reg_addr_t rk,
                                 input reg_addr_t rj, input reg_addr_t rd);
    return {opc, rk, rj, rd};
endfunction

function automatic word_t enc_2ri12(input logic [9:0] opc, input logic [11:0] si12,
                                    input reg_addr_t rj, input reg_addr_t rd);
    return {opc, si12, rj, rd};
endfunction

function automatic word_t enc_2ri16(input logic [5:0] opc, input logic [15:0] offs,
                                    input reg_addr_t rj, input reg_addr_t rd);
    return {opc, offs, rj, rd};
endfunction

function automatic word_t enc_i26(input logic [5:0] opc, input logic [25:0] offs);
    return {opc, offs[15:0], offs[25:16]};  // high part goes low
endfunction

function automatic word_t enc_1ri20(input logic [6:0] opc, input logic [19:0] si20,
                                    input reg_addr_t rd);
    return {opc, si20, rd};
endfunction

`endif

//--- test/tb_id_stage.sv
// decode stage testbench
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    `include "tb_id_model.svh"

    localparam int MAX_CYCLES = 400;  // tests need under 150 cycles

    localparam logic [16:0] RR_ENC [5] = '{ENC_ADD_W, ENC_SUB_W, ENC_AND, ENC_SLT, ENC_MUL_W};
    localparam alu_op_e     RR_OP  [5] = '{OP_ADD, OP_SUB, OP_AND, OP_SLT, OP_MUL};
    localparam alu_sel_e    RR_SEL [5] = '{SEL_ARITH, SEL_ARITH, SEL_LOGIC, SEL_ARITH,
                                           SEL_ARITH};

    logic       clk_i;
    logic       rst_n_i;
    word_t      pc_i;
    word_t      inst_i;
    word_t      reg1_i;
    word_t      reg2_i;
    fwd_src_t   ex_fwd_i;
    fwd_src_t   mem_fwd_i;
    logic       is_in_delayslot_i;
    reg_addr_t  raddr1_o;
    reg_addr_t  raddr2_o;
    logic       reg1_re_o;
    logic       reg2_re_o;
    branch_t    br_o;
    ex_bundle_t ex_o;

    word_t      rf [32];  // register file model
    fwd_src_t   nxt_ex_fwd;
    fwd_src_t   nxt_mem_fwd;
    logic       nxt_dly;
    int         cycles;
    int         checks;
    int         errors;
    int         tests_run;
    int         errs_before;

    word_t       r, a, b, pc, tgt;
    logic [11:0] si;
    reg_addr_t   rj, rk, rd;
    int          k;
    logic        taken;
    logic        p_valid;
    alu_op_e     p_op;
    alu_sel_e    p_sel;
    word_t       p_r1, p_r2;
    reg_addr_t   p_rd;

    id_stage dut_i (.*);

    assign reg1_i = rf[raddr1_o];
    assign reg2_i = rf[raddr2_o];

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // no taken branch means an all-zero branch output
    br_quiet: assert property (@(negedge clk_i)
        (br_o.next_in_delayslot == br_o.flag) && (br_o.flag || br_o.target == '0))
    else begin
        errors++;
        $display("branch output inconsistent: flag %0b target %h delay slot %0b",
                 br_o.flag, br_o.target, br_o.next_in_delayslot);
    end

    //////////////////////////////////////////////////
    // check and drive helpers
    //////////////////////////////////////////////////
    task automatic check_val(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic present(input word_t inst, input word_t pc_val);
        @(posedge clk_i);
        #1;
        inst_i            = inst;
        pc_i              = pc_val;
        ex_fwd_i          = nxt_ex_fwd;
        mem_fwd_i         = nxt_mem_fwd;
        is_in_delayslot_i = nxt_dly;
        #40;  // settled, well before the next edge
    endtask

    task automatic insert_nop();
        present(32'h0, 32'h0);
    endtask

    task automatic check_reads(input logic re1, input logic re2);
        check_val("reg1_re_o", 32'(reg1_re_o), 32'(re1));
        check_val("reg2_re_o", 32'(reg2_re_o), 32'(re2));
    endtask

    task automatic check_operands(input word_t r1, input word_t r2, input reg_addr_t wa,
                                  input logic we);
        check_val("ex_o.reg1", ex_o.reg1, r1);
        check_val("ex_o.reg2", ex_o.reg2, r2);
        check_val("ex_o.waddr", 32'(ex_o.waddr), 32'(wa));
        check_val("ex_o.we", 32'(ex_o.we), 32'(we));
    endtask

    task automatic check_ex(input alu_op_e op, input alu_sel_e sel, input word_t r1,
                            input word_t r2, input reg_addr_t wa);
        check_val("ex_o.aluop", 32'(ex_o.aluop), 32'(op));
        check_val("ex_o.alusel", 32'(ex_o.alusel), 32'(sel));
        check_operands(r1, r2, wa, 1'b1);
    endtask

    task automatic check_branch(input logic flag, input word_t target);
        check_val("br_o.flag", 32'(br_o.flag), 32'(flag));
        check_val("br_o.target", br_o.target, target);
        check_val("br_o.next_in_delayslot", 32'(br_o.next_in_delayslot), 32'(flag));
    endtask

    task automatic check_link(input word_t link, input reg_addr_t wa);
        check_val("ex_o.link_addr", ex_o.link_addr, link);
        check_val("ex_o.waddr", 32'(ex_o.waddr), 32'(wa));
        check_val("ex_o.we", 32'(ex_o.we), 32'd1);
    endtask

    // ADD_W with the given forwarding inputs, operands checked in ex_o
    task automatic forward_case(input fwd_src_t exf, input fwd_src_t memf,
                                input reg_addr_t src1, input reg_addr_t src2,
                                input word_t exp1, input word_t exp2);
        nxt_ex_fwd  = exf;
        nxt_mem_fwd = memf;
        present(enc_3r(ENC_ADD_W, src2, src1, 5'd9), 32'h0);
        nxt_ex_fwd  = '0;
        nxt_mem_fwd = '0;
        insert_nop();
        check_operands(exp1, exp2, 5'd9, 1'b1);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (errors == errs_before) ? "ok" : "failed", errors - errs_before);
        errs_before = errors;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        rst_n_i           = 1'b0;
        pc_i              = '0;
        inst_i            = enc_3r(ENC_ADD_W, 5'd2, 5'd1, 5'd3);  // writes r3 unless reset
        ex_fwd_i          = '0;
        mem_fwd_i         = '0;
        is_in_delayslot_i = 1'b0;
        nxt_ex_fwd        = '0;
        nxt_mem_fwd       = '0;
        nxt_dly           = 1'b0;
        rf[0]             = '0;
        for (int i = 1; i < 32; i++)
            rf[i] = next_rand();

        for (int i = 1; i <= 5; i++) begin
            @(posedge clk_i);
            #1;
            if (i == 4) begin
                rst_n_i = 1'b1;  // four edges seen low
                inst_i  = '0;
            end
            #40;
            check_val("ex_o.we", 32'(ex_o.we), 32'd0);
            check_val("ex_o.alusel", 32'(ex_o.alusel), 32'(SEL_NOP));
        end
        report_test("reset");

        p_valid = 1'b0;
        for (int i = 0; i <= 20; i++) begin
            r  = next_rand();
            k  = int'(r[31:16] % 5);
            rd = r[4:0];
            rj = r[9:5];
            rk = r[14:10];
            present((i < 20) ? enc_3r(RR_ENC[k], rk, rj, rd) : 32'h0, {r[29:0], 2'b00});
            if (p_valid)
                check_ex(p_op, p_sel, p_r1, p_r2, p_rd);  // previous instruction
            if (i < 20) begin
                check_val("raddr1_o", 32'(raddr1_o), 32'(rj));
                check_val("raddr2_o", 32'(raddr2_o), 32'(rk));
                check_reads(1'b1, 1'b1);
            end
            p_valid = 1'b1;
            p_op    = RR_OP[k];
            p_sel   = RR_SEL[k];
            p_r1    = rf[rj];
            p_r2    = rf[rk];
            p_rd    = rd;
        end
        report_test("reg-reg");

        r  = next_rand();
        rj = r[4:0];
        rd = r[9:5];
        rk = r[14:10];
        si = {1'b1, r[25:15]};  // negative as si12
        present(enc_2ri12(ENC_ORI, si, rj, rd), 32'h0);
        check_reads(1'b1, 1'b0);
        insert_nop();
        check_ex(OP_OR, SEL_LOGIC, rf[rj], {20'h0, si}, rd);
        present(enc_2ri12(ENC_ADDI_W, si, rj, rd), 32'h0);
        insert_nop();
        check_ex(OP_ADD, SEL_ARITH, rf[rj], {{20{si[11]}}, si}, rd);
        present(enc_2ri12(ENC_LD_W, si, rj, rd), 32'h0);
        insert_nop();
        check_ex(OP_LD_W, SEL_LOAD_STORE, rf[rj], {{20{si[11]}}, si}, rd);
        present(enc_1ri20(ENC_LU12I_W, r[31:12], rd), 32'h0);
        insert_nop();
        check_operands(32'h0, {r[31:12], 12'h000}, rd, 1'b1);
        present(enc_3r(ENC_SLLI_W, rk, rj, rd), 32'h0);
        insert_nop();
        check_ex(OP_SLL, SEL_SHIFT, rf[rj], {27'h0, rk}, rd);
        present(enc_2ri12(ENC_ST_W, si, rj, rd), 32'h0);
        check_reads(1'b1, 1'b1);
        insert_nop();
        check_val("ex_o.aluop", 32'(ex_o.aluop), 32'(OP_ST_W));
        check_val("ex_o.reg1", ex_o.reg1, rf[rj]);
        check_val("ex_o.reg2", ex_o.reg2, rf[rd]);  // store data
        check_val("ex_o.imm", ex_o.imm, {{20{si[11]}}, si});
        check_val("ex_o.we", 32'(ex_o.we), 32'd0);
        report_test("immediate");

        r  = next_rand();
        rj = {1'b0, r[3:0]} | 5'd1;
        rk = {1'b1, r[7:4]};
        a  = next_rand();
        b  = next_rand();
        forward_case(fwd_src_t'{1'b1, rj, a}, fwd_src_t'{1'b1, rj, b}, rj, rk, a, rf[rk]);
        forward_case(fwd_src_t'{1'b0, rk, a}, fwd_src_t'{1'b1, rk, b}, rj, rk, rf[rj], b);
        forward_case(fwd_src_t'{1'b1, 5'd0, a}, fwd_src_t'{1'b0, rk, b}, 5'd0, rk,
                     32'h0, rf[rk]);
        report_test("forwarding");

        for (k = 0; k < 6; k++) begin
            for (int j = 0; j < 4; j++) begin
                r = next_rand();
                a = (j == 1) ? 32'h7fff_ffff : (j == 2) ? 32'h8000_0000 : r;
                case (j)
                    0:       b = r;
                    1:       b = 32'h8000_0000;
                    2:       b = 32'h7fff_ffff;
                    default: b = next_rand();
                endcase
                case (k)
                    0:       taken = (a == b);
                    1:       taken = (a != b);
                    2:       taken = ($signed(a) < $signed(b));
                    3:       taken = ($signed(a) >= $signed(b));
                    4:       taken = (a < b);
                    default: taken = (a >= b);
                endcase
                rj          = {1'b0, r[3:0]} | 5'd1;
                rd          = {1'b1, r[7:4]};
                nxt_ex_fwd  = fwd_src_t'{1'b1, rj, a};  // operands via forwarding
                nxt_mem_fwd = fwd_src_t'{1'b1, rd, b};
                pc          = {r[31:2], 2'b00};
                tgt         = pc + {{14{r[23]}}, r[23:8], 2'b00};
                present(enc_2ri16(ENC_BEQ + 6'(k), r[23:8], rj, rd), pc);
                check_branch(taken, taken ? tgt : 32'h0);
            end
        end
        nxt_ex_fwd  = '0;
        nxt_mem_fwd = '0;
        report_test("cond branch");

        pc = next_rand() & 32'hffff_fffc;
        r  = next_rand();
        present(enc_i26(ENC_B, r[25:0]), pc);
        check_branch(1'b1, pc + {{4{r[25]}}, r[25:0], 2'b00});
        check_reads(1'b0, 1'b0);
        present(enc_i26(ENC_BL, r[25:0]), pc + 32'd4);
        check_branch(1'b1, pc + 32'd4 + {{4{r[25]}}, r[25:0], 2'b00});
        a          = next_rand();
        rd         = r[30:26];
        nxt_ex_fwd = fwd_src_t'{1'b1, 5'd3, a};
        present(enc_2ri16(ENC_JIRL, r[15:0], 5'd3, rd), pc + 32'd8);
        check_branch(1'b1, a + {{14{r[15]}}, r[15:0], 2'b00});
        check_link(pc + 32'd8, 5'd1);  // BL, one cycle later
        nxt_ex_fwd = '0;
        insert_nop();
        check_link(pc + 32'd12, rd);
        report_test("jumps");

        nxt_dly = 1'b1;
        present(32'hfc00_0000, pc);
        check_branch(1'b0, 32'h0);
        check_reads(1'b0, 1'b0);
        nxt_dly = 1'b0;
        insert_nop();
        check_val("ex_o.we", 32'(ex_o.we), 32'd0);
        check_val("ex_o.alusel", 32'(ex_o.alusel), 32'(SEL_NOP));
        check_val("ex_o.is_in_delayslot", 32'(ex_o.is_in_delayslot), 32'd1);
        report_test("unknown");

        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+test
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
test/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_id_stage -Mdir "$BUILD" -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/Vtb_id_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
